// File: mem_system.f
+incdir+.
mem_system_pkg.sv
cache_array.sv
four_bank_mem.sv
cache_ctrl.sv
mem_system.sv
mem_system_assert.sv
mem_system_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = mem_system_tb
FILELIST  = mem_system.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

// File: mem_system_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_system_defs.svh"

module mem_system_tb
   import mem_system_pkg::*;
();

   localparam int DONE_TIMEOUT = 100;
   localparam int NUM_REQ      = 400;
   localparam int HIT_CYCLES   = 2;
   localparam int LINES        = 1 << `INDEX_W;

   logic  clk;
   logic  rst_n;
   logic  rd;
   logic  wr;
   addr_t addr;
   word_t data_in;
   word_t data_out;
   logic  done;
   logic  stall;
   logic  cache_hit;
   logic  err;

   // reference model of word memory and per-line tags
   word_t mem_model [`MEM_WORDS];
   logic  line_valid [LINES];
   tag_t  line_tag [LINES];

   mem_system DUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd        (rd),
      .wr        (wr),
      .addr      (addr),
      .data_in   (data_in),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   always #5 clk = ~clk;

   task automatic check_word(input string name, input word_t expected, input word_t actual);
      if (expected !== actual) begin
         $display("TEST FAIL");
         $display("Fail %s: expected %h, actual %h", name, expected, actual);
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (expected !== actual) begin
         $display("TEST FAIL");
         $display("Fail %s: expected %b, actual %b", name, expected, actual);
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic check_cycles(input string name, input int expected, input int actual);
      if (expected != actual) begin
         $display("TEST FAIL");
         $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   function automatic addr_t make_addr(input tag_t tag, input index_t idx, input wsel_t ws);
      return {tag, idx, ws, 1'b0};
   endfunction

   // samples on the falling edge and counts cycles since the request went out
   task automatic wait_done(input string name, input logic miss, output int cycles);
      logic seen;
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < DONE_TIMEOUT) begin
         @(negedge clk);
         cycles++;
         seen = done;
         // a miss stalls from the first cycle after acceptance until done
         if (!seen) begin
            check_flag({name, " stall"}, miss && cycles >= HIT_CYCLES, stall);
         end
      end
      if (!seen) begin
         $display("TEST FAIL");
         $fatal(1, "%s: no done within %0d cycles", name, DONE_TIMEOUT);
      end
   endtask

   // called and returns just after a rising edge
   task automatic do_request(input string name, input logic is_wr, input addr_t a,
                             input word_t d);
      int     cycles;
      index_t idx;
      tag_t   tag;
      logic   exp_hit;
      logic   miss;
      word_t  exp_data;
      idx      = a[10:3];
      tag      = a[15:11];
      exp_hit  = line_valid[idx] && (line_tag[idx] == tag);
      miss     = !a[0] && !exp_hit;
      exp_data = mem_model[a[15:1]];
      rd       = ~is_wr;
      wr       = is_wr;
      addr     = a;
      data_in  = d;
      wait_done(name, miss, cycles);
      if (a[0]) begin
         check_flag({name, " err"}, 1'b1, err);
         check_flag({name, " hit"}, 1'b0, cache_hit);
         check_cycles({name, " err latency"}, HIT_CYCLES, cycles);
      end else begin
         check_flag({name, " err"}, 1'b0, err);
         check_flag({name, " hit"}, exp_hit, cache_hit);
         if (exp_hit) begin
            check_cycles({name, " hit latency"}, HIT_CYCLES, cycles);
         end
         if (is_wr) begin
            mem_model[a[15:1]] = d;
         end else begin
            check_word({name, " data"}, exp_data, data_out);
         end
         line_valid[idx] = 1'b1;
         line_tag[idx]   = tag;
      end
      @(posedge clk);
      #1;
      rd = 1'b0;
      wr = 1'b0;
   endtask

   initial begin
      addr_t a;
      void'($urandom(32'h8314));
      clk     = 1'b0;
      rst_n   = 1'b0;
      rd      = 1'b0;
      wr      = 1'b0;
      addr    = '0;
      data_in = '0;
      for (int i = 0; i < `MEM_WORDS; i++) begin
         mem_model[i] = '0;
      end
      for (int i = 0; i < LINES; i++) begin
         line_valid[i] = 1'b0;
         line_tag[i]   = '0;
      end

      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      check_flag("reset done", 1'b0, done);
      check_flag("reset stall", 1'b0, stall);
      check_flag("reset cache_hit", 1'b0, cache_hit);
      check_flag("reset err", 1'b0, err);
      @(posedge clk);
      #1;

      // dirty line pushed out by a conflict and then brought back
      do_request("first_read", 1'b0, make_addr(5'd1, 8'd5, 2'd2), '0);
      do_request("wb_write", 1'b1, make_addr(5'd1, 8'd5, 2'd2), 16'hbeef);
      do_request("wb_conflict", 1'b0, make_addr(5'd2, 8'd5, 2'd2), '0);
      do_request("wb_reread", 1'b0, make_addr(5'd1, 8'd5, 2'd2), '0);

      // odd address must leave the word alone
      a = make_addr(5'd1, 8'd5, 2'd2);
      do_request("odd_write", 1'b1, a | addr_t'(1), 16'h1234);
      do_request("odd_follow", 1'b0, a, '0);

      for (int i = 0; i < NUM_REQ; i++) begin
         a = make_addr(tag_t'($urandom_range(3, 0)), index_t'($urandom_range(7, 0)),
                       wsel_t'($urandom_range(3, 0)));
         if ($urandom_range(15, 0) == 0) begin
            a[0] = 1'b1;
         end
         do_request("random", $urandom_range(1, 0) == 1, a, word_t'($urandom));
      end

      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: mem_system_assert.sv
`timescale 1ns/1ps
`default_nettype none

module mem_system_assert (
   input wire clk,
   input wire rst_n,
   input wire done,
   input wire stall,
   input wire cache_hit,
   input wire err,
   input wire mem_rd,
   input wire mem_wr
);

   // done is a single-cycle pulse
   done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
      else $error("done held high for more than one cycle");

   done_not_stall: assert property (@(posedge clk) disable iff (!rst_n) !(done && stall))
      else $error("done and stall high in the same cycle");

   // misaligned access never counts as a hit
   err_with_done: assert property (@(posedge clk) disable iff (!rst_n)
                                   err |-> (done && !cache_hit))
      else $error("err without done, or together with cache_hit");

   mem_one_op: assert property (@(posedge clk) disable iff (!rst_n) !(mem_rd && mem_wr))
      else $error("memory read and write issued together");

endmodule

bind cache_ctrl mem_system_assert u_assert (
   .clk       (clk),
   .rst_n     (rst_n),
   .done      (done),
   .stall     (stall),
   .cache_hit (cache_hit),
   .err       (err),
   .mem_rd    (mem_rd),
   .mem_wr    (mem_wr)
);

`default_nettype wire

// File: mem_system.sv
`timescale 1ns/1ps
`default_nettype none

module mem_system
   import mem_system_pkg::*;
(
   input  wire        clk,
   input  wire        rst_n,
   input  wire        rd,
   input  wire        wr,
   input  wire addr_t addr,
   input  wire word_t data_in,
   output word_t      data_out,
   output logic       done,
   output logic       stall,
   output logic       cache_hit,
   output logic       err
);

   // controller to cache array
   logic   cache_enable;
   logic   cache_comp;
   logic   cache_write;
   logic   cache_valid_in;
   tag_t   cache_tag_in;
   index_t cache_index;
   wsel_t  cache_word_sel;
   word_t  cache_wdata;
   tag_t   cache_tag_out;
   word_t  cache_rdata;
   logic   cache_hit_raw;
   logic   cache_dirty;
   logic   cache_valid;

   // controller to memory
   addr_t mem_addr;
   word_t mem_wdata;
   word_t mem_rdata;
   logic  mem_wr;
   logic  mem_rd;
   logic  mem_stall;

   cache_ctrl u_ctrl (
      .clk            (clk),
      .rst_n          (rst_n),
      .rd             (rd),
      .wr             (wr),
      .addr           (addr),
      .data_in        (data_in),
      .cache_tag_out  (cache_tag_out),
      .cache_data_out (cache_rdata),
      .mem_rdata      (mem_rdata),
      .cache_hit_raw  (cache_hit_raw),
      .cache_dirty    (cache_dirty),
      .cache_valid    (cache_valid),
      .mem_stall      (mem_stall),
      .data_out       (data_out),
      .done           (done),
      .stall          (stall),
      .cache_hit      (cache_hit),
      .err            (err),
      .cache_enable   (cache_enable),
      .cache_comp     (cache_comp),
      .cache_write    (cache_write),
      .cache_valid_in (cache_valid_in),
      .cache_tag_in   (cache_tag_in),
      .cache_index    (cache_index),
      .cache_word_sel (cache_word_sel),
      .cache_data_in  (cache_wdata),
      .mem_addr       (mem_addr),
      .mem_wdata      (mem_wdata),
      .mem_wr         (mem_wr),
      .mem_rd         (mem_rd)
   );

   cache_array u_cache (
      .clk      (clk),
      .rst_n    (rst_n),
      .enable   (cache_enable),
      .comp     (cache_comp),
      .write    (cache_write),
      .valid_in (cache_valid_in),
      .tag_in   (cache_tag_in),
      .index    (cache_index),
      .word_sel (cache_word_sel),
      .data_in  (cache_wdata),
      .tag_out  (cache_tag_out),
      .data_out (cache_rdata),
      .hit      (cache_hit_raw),
      .dirty    (cache_dirty),
      .valid    (cache_valid)
   );

   four_bank_mem u_mem (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr       (mem_wr),
      .rd       (mem_rd),
      .addr     (mem_addr),
      .data_in  (mem_wdata),
      .data_out (mem_rdata),
      .stall    (mem_stall),
      .busy     ()
   );

endmodule

`default_nettype wire

// File: cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_system_defs.svh"

module cache_ctrl
   import mem_system_pkg::*;
(
   input  wire         clk,
   input  wire         rst_n,
   input  wire         rd,
   input  wire         wr,
   input  wire addr_t  addr,
   input  wire word_t  data_in,
   input  wire tag_t   cache_tag_out,
   input  wire word_t  cache_data_out,
   input  wire word_t  mem_rdata,
   input  wire         cache_hit_raw,
   input  wire         cache_dirty,
   input  wire         cache_valid,
   input  wire         mem_stall,
   output word_t       data_out,
   output logic        done,
   output logic        stall,
   output logic        cache_hit,
   output logic        err,
   output logic        cache_enable,
   output logic        cache_comp,
   output logic        cache_write,
   output logic        cache_valid_in,
   output tag_t        cache_tag_in,
   output index_t      cache_index,
   output wsel_t       cache_word_sel,
   output word_t       cache_data_in,
   output addr_t       mem_addr,
   output word_t       mem_wdata,
   output logic        mem_wr,
   output logic        mem_rd
);

   ctrl_state_t state;
   ctrl_state_t state_next;

   tag_t   req_tag;
   index_t req_index;
   wsel_t  req_wsel;
   tag_t   victim_tag;
   wsel_t  step;
   logic   line_hit;
   logic   rd_issue;

   // tracks accepted fill reads until their data returns
   logic [`MEM_READ_LAT-1:0] ret_vld;
   wsel_t                    ret_wsel [`MEM_READ_LAT];

   function automatic wsel_t step_of(ctrl_state_t s);
      case (s)
         WB1, ALLOC1: return 2'd1;
         WB2, ALLOC2: return 2'd2;
         WB3, ALLOC3: return 2'd3;
         default:     return 2'd0;
      endcase
   endfunction

   // address decode
   assign req_tag   = addr[15:11];
   assign req_index = addr[10:3];
   assign req_wsel  = addr[2:1];

   assign step     = step_of(state);
   assign line_hit = cache_hit_raw & cache_valid;
   assign rd_issue = mem_rd & ~mem_stall;

   assign cache_index = req_index;
   assign mem_wdata   = cache_data_out;
   assign data_out    = cache_data_out;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= IDLE;
      end else begin
         state <= state_next;
      end
   end

   always_ff @(posedge clk) begin
      if (state == COMP1) begin
         victim_tag <= cache_tag_out;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ret_vld <= '0;
      end else begin
         ret_vld[0] <= rd_issue;
         for (int i = 1; i < `MEM_READ_LAT; i++) begin
            ret_vld[i] <= ret_vld[i-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      ret_wsel[0] <= mem_addr[2:1];
      for (int i = 1; i < `MEM_READ_LAT; i++) begin
         ret_wsel[i] <= ret_wsel[i-1];
      end
   end

   always_comb begin
      state_next     = state;
      done           = 1'b0;
      stall          = 1'b0;
      cache_hit      = 1'b0;
      err            = 1'b0;
      cache_enable   = 1'b0;
      cache_comp     = 1'b0;
      cache_write    = 1'b0;
      cache_valid_in = 1'b0;
      cache_tag_in   = req_tag;
      cache_word_sel = req_wsel;
      cache_data_in  = data_in;
      mem_addr       = '0;
      mem_wr         = 1'b0;
      mem_rd         = 1'b0;

      case (state)
         IDLE: begin
            if (rd || wr) begin
               state_next = addr[0] ? ERR : COMP1;
            end
         end
         ERR: begin
            done       = 1'b1;
            err        = 1'b1;
            state_next = IDLE;
         end
         COMP1: begin
            cache_enable = 1'b1;
            cache_comp   = 1'b1;
            cache_write  = wr;
            if (line_hit) begin
               done       = 1'b1;
               cache_hit  = 1'b1;
               state_next = IDLE;
            end else begin
               stall      = 1'b1;
               state_next = (cache_valid && cache_dirty) ? WB0 : ALLOC0;
            end
         end
         WB0, WB1, WB2, WB3: begin
            stall          = 1'b1;
            cache_enable   = 1'b1;
            cache_word_sel = step;
            mem_addr       = {victim_tag, req_index, step, 1'b0};
            mem_wr         = 1'b1;
            if (!mem_stall) begin
               state_next = ctrl_state_t'(state + 4'd1);
            end
         end
         ALLOC0, ALLOC1, ALLOC2, ALLOC3: begin
            stall    = 1'b1;
            mem_addr = {req_tag, req_index, step, 1'b0};
            mem_rd   = 1'b1;
            if (!mem_stall) begin
               state_next = ctrl_state_t'(state + 4'd1);
            end
         end
         ALLOC4, ALLOC5: begin
            // last fill words still on their way back
            stall      = 1'b1;
            state_next = ctrl_state_t'(state + 4'd1);
         end
         COMP2: begin
            done         = 1'b1;
            cache_enable = 1'b1;
            cache_comp   = 1'b1;
            cache_write  = wr;
            state_next   = IDLE;
         end
         default: begin
            state_next = IDLE;
         end
      endcase

      // fill capture follows the returning reads, not the issue state
      if (ret_vld[`MEM_READ_LAT-1]) begin
         cache_enable   = 1'b1;
         cache_comp     = 1'b0;
         cache_write    = 1'b1;
         cache_valid_in = 1'b1;
         cache_word_sel = ret_wsel[`MEM_READ_LAT-1];
         cache_data_in  = mem_rdata;
      end
   end

endmodule

`default_nettype wire

// File: four_bank_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_system_defs.svh"

module four_bank_mem
   import mem_system_pkg::*;
(
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire                    wr,
   input  wire                    rd,
   input  wire addr_t             addr,
   input  wire word_t             data_in,
   output word_t                  data_out,
   output logic                   stall,
   output logic [`LINE_WORDS-1:0] busy
);

   localparam int BANK_DEPTH = `MEM_WORDS / `LINE_WORDS;
   localparam int ROW_W      = $clog2(BANK_DEPTH);
   localparam int CNT_W      = $clog2(`BANK_BUSY_CYCLES + 1);

   word_t            bank_mem [`LINE_WORDS][BANK_DEPTH];
   logic [CNT_W-1:0] busy_cnt [`LINE_WORDS];
   word_t            rd_pipe [`MEM_READ_LAT];

   wsel_t            bank;
   logic [ROW_W-1:0] row;
   logic             req;
   logic             accept;

   // word address bits 2:1 pick the bank and the rest the row
   assign bank = addr[2:1];
   assign row  = addr[ROW_W+2:3];
   assign req  = rd | wr;

   always_comb begin
      for (int b = 0; b < `LINE_WORDS; b++) begin
         busy[b] = (busy_cnt[b] != '0);
      end
   end

   // an access to a busy bank is dropped
   assign stall  = req & busy[bank];
   assign accept = req & ~busy[bank];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int b = 0; b < `LINE_WORDS; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < `LINE_WORDS; b++) begin
            if (accept && bank == wsel_t'(b)) begin
               busy_cnt[b] <= CNT_W'(`BANK_BUSY_CYCLES);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int b = 0; b < `LINE_WORDS; b++) begin
            for (int r = 0; r < BANK_DEPTH; r++) begin
               bank_mem[b][r] <= '0;
            end
         end
      end else if (accept && wr) begin
         bank_mem[bank][row] <= data_in;
      end
   end

   // several reads can be in flight in the read pipeline
   always_ff @(posedge clk) begin
      rd_pipe[0] <= (accept && rd) ? bank_mem[bank][row] : '0;
      for (int i = 1; i < `MEM_READ_LAT; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   assign data_out = rd_pipe[`MEM_READ_LAT-1];

endmodule

`default_nettype wire

// File: cache_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_system_defs.svh"

module cache_array
   import mem_system_pkg::*;
(
   input  wire         clk,
   input  wire         rst_n,
   input  wire         enable,
   input  wire         comp,
   input  wire         write,
   input  wire         valid_in,
   input  wire tag_t   tag_in,
   input  wire index_t index,
   input  wire wsel_t  word_sel,
   input  wire word_t  data_in,
   output tag_t        tag_out,
   output word_t       data_out,
   output logic        hit,
   output logic        dirty,
   output logic        valid
);

   localparam int LINES = 1 << `INDEX_W;

   tag_t             tag_mem [LINES];
   word_t            data_mem [LINES][`LINE_WORDS];
   logic [LINES-1:0] valid_bits;
   logic [LINES-1:0] dirty_bits;

   logic tag_match;
   logic line_hit;
   logic comp_wr;
   logic fill_wr;

   assign tag_match = (tag_mem[index] == tag_in);
   assign line_hit  = tag_match & valid_bits[index];

   // compare write only lands on a valid matching line
   assign comp_wr = enable & write & comp & line_hit;
   assign fill_wr = enable & write & ~comp;

   assign tag_out  = tag_mem[index];
   assign data_out = data_mem[index][word_sel];
   assign hit      = enable & comp & tag_match;
   assign dirty    = dirty_bits[index];
   assign valid    = valid_bits[index];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (fill_wr) begin
         valid_bits[index] <= valid_in;
         dirty_bits[index] <= 1'b0;
      end else if (comp_wr) begin
         dirty_bits[index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (fill_wr || comp_wr) begin
         data_mem[index][word_sel] <= data_in;
      end
      // fills also take the new tag
      if (fill_wr) begin
         tag_mem[index] <= tag_in;
      end
   end

endmodule

`default_nettype wire

// File: mem_system_pkg.sv
`default_nettype none

package mem_system_pkg;

`include "mem_system_defs.svh"

   typedef logic [`ADDR_W-1:0]  addr_t;
   typedef logic [`DATA_W-1:0]  word_t;
   typedef logic [`TAG_W-1:0]   tag_t;
   typedef logic [`INDEX_W-1:0] index_t;
   // word within a line and also the bank number
   typedef logic [`WSEL_W-1:0]  wsel_t;

   // WB and ALLOC states are numbered consecutively
   typedef enum logic [3:0] {
      IDLE   = 4'd0,
      ERR    = 4'd1,
      COMP1  = 4'd2,
      WB0    = 4'd3,
      WB1    = 4'd4,
      WB2    = 4'd5,
      WB3    = 4'd6,
      ALLOC0 = 4'd7,
      ALLOC1 = 4'd8,
      ALLOC2 = 4'd9,
      ALLOC3 = 4'd10,
      ALLOC4 = 4'd11,
      ALLOC5 = 4'd12,
      COMP2  = 4'd13
   } ctrl_state_t;

endpackage

`default_nettype wire

// File: mem_system_defs.svh
`ifndef MEM_SYSTEM_DEFS_SVH
`define MEM_SYSTEM_DEFS_SVH

// widths
`define ADDR_W 16
`define DATA_W 16

// address split into tag, index, word select and byte bit
`define TAG_W 5
`define INDEX_W 8
`define WSEL_W 2

// cache geometry
`define LINE_WORDS 4

// main memory size in 16-bit words
`define MEM_WORDS 32768

// bank timing
`define BANK_BUSY_CYCLES 4
`define MEM_READ_LAT 2

`endif
